// ==== dv/acia_tb.sv ====
`timescale 1ns/1ps

module acia_tb
	import serial_pkg::*;
	import acia_pkg::*;
();

	localparam int cpb          = 16; // short bit period for simulation
	localparam int clk_period   = 40;
	localparam int frame_cycles = frame_bits * cpb;
	localparam int warmup_clks  = warmup_bits * cpb;
	localparam int test_frames  = 40;
	localparam int watchdog_ns  = 2 * test_frames * frame_cycles * clk_period;

	logic     clk;
	logic     reset;
	reg_sel_t addr;
	byte_t    data_in;
	logic     rd;
	logic     we;
	logic     rx;
	byte_t    data_out;
	logic     tx;

	int     errors;
	int     checks;
	int     cycle;
	integer seed;

	clk_gen #(.half_period(clk_period / 2)) u_clk_gen (.clk(clk));

	acia #(.clks_per_bit(cpb)) u_acia (
		.clk      (clk),
		.reset    (reset),
		.addr     (addr),
		.data_in  (data_in),
		.rd       (rd),
		.we       (we),
		.rx       (rx),
		.data_out (data_out),
		.tx       (tx)
	);

	always @(posedge clk)
		cycle <= cycle + 1; // free-running cycle count

	// ----------------------------------------
	// bus and serial helpers
	// ----------------------------------------
	task automatic next_cycle();
		@(posedge clk);
		#2; // drive just after the edge
	endtask

	task automatic check_byte(input string name, input byte_t expected, input byte_t actual);
		checks++;
		if (actual !== expected) begin
			$display("error at %0t ns: %s expected %02h, got %02h",
				$time, name, expected, actual);
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		checks++;
		if (actual !== expected) begin
			$display("error at %0t ns: %s expected %b, got %b",
				$time, name, expected, actual);
			errors++;
		end
	endtask

	task automatic write_reg(input reg_sel_t sel, input byte_t value);
		addr    = sel;
		data_in = value;
		we      = 1'b1;
		next_cycle();
		we = 1'b0;
	endtask

	task automatic read_reg(input reg_sel_t sel, output byte_t value);
		addr = sel;
		rd   = 1'b1;
		next_cycle();
		rd    = 1'b0;
		value = data_out; // loaded on the edge that took rd
	endtask

	task automatic expect_status(input logic rdrf, input logic tdre);
		byte_t value;
		read_reg(reg_status, value);
		check_bit("status rdrf", rdrf, value[stat_rdrf]);
		check_bit("status tdre", tdre, value[stat_tdre]);
		check_bit("status irq", rdrf, value[stat_irq]);
		check_byte("status unused bits", 8'h00, value & 8'hdc);
	endtask

	// poll the status register until a bit reaches the level
	task automatic wait_status(input int pos, input logic level, input int limit);
		byte_t value;
		int    start;
		start = cycle;
		read_reg(reg_status, value);
		while (value[pos] !== level && cycle - start < limit)
			read_reg(reg_status, value);
		if (value[pos] !== level) begin
			$display("status bit %0d did not reach %b within %0d cycles", pos, level, limit);
			errors++;
		end
	endtask

	task automatic send_serial(input byte_t value);
		logic [frame_bits-1:0] frame;
		frame = {1'b1, value, 1'b0}; // stop, data, start
		for (int i = 0; i < frame_bits; i++) begin
			rx = frame[i];
			repeat (cpb) next_cycle();
		end
	endtask

	task automatic capture_serial(output byte_t value);
		int waited;
		waited = 0;
		value  = '0;
		while (tx === 1'b1 && waited < 2 * frame_cycles) begin
			next_cycle();
			waited++;
		end
		if (tx !== 1'b0) begin
			$display("no start bit appeared on tx within %0d cycles", 2 * frame_cycles);
			errors++;
		end else begin
			repeat (cpb / 2) next_cycle(); // middle of start bit
			check_bit("tx start bit", 1'b0, tx);
			for (int i = 0; i < data_bits; i++) begin
				repeat (cpb) next_cycle();
				value[i] = tx;
			end
			repeat (cpb) next_cycle();
			check_bit("tx stop bit", 1'b1, tx);
		end
	endtask

	// ----------------------------------------
	// directed tests
	// ----------------------------------------
	task automatic startup_idle();
		byte_t got;
		int    release_cycle;
		int    elapsed;
		release_cycle = cycle;
		check_byte("data_out after reset", 8'h00, data_out);
		expect_status(1'b0, 1'b0);
		read_reg(reg_data, got);
		check_byte("empty data read", empty_read, got);
		wait_status(stat_tdre, 1'b1, warmup_clks + frame_cycles);
		elapsed = cycle - release_cycle; // includes one read cycle
		if (elapsed < warmup_clks || elapsed > warmup_clks + 2) begin
			$display("tdre rose %0d cycles after reset, expected about %0d",
				elapsed, warmup_clks);
			errors++;
		end
	endtask

	task automatic transmit_frame(input byte_t value);
		byte_t got;
		write_reg(reg_data, value);
		fork
			capture_serial(got);
			begin
				repeat (cpb) next_cycle();
				expect_status(1'b0, 1'b0); // busy mid-frame
			end
		join
		check_byte("tx char", {1'b0, value[6:0]}, got);
		wait_status(stat_tdre, 1'b1, 2 * cpb);
	endtask

	task automatic busy_write(input byte_t first, input byte_t second);
		byte_t got;
		int    low_cycles;
		write_reg(reg_data, first);
		fork
			capture_serial(got);
			begin
				repeat (3 * cpb) next_cycle();
				write_reg(reg_data, second);
			end
		join
		check_byte("tx char", {1'b0, first[6:0]}, got);
		wait_status(stat_tdre, 1'b1, 2 * cpb);
		low_cycles = 0;
		repeat (frame_cycles) begin
			next_cycle();
			if (tx !== 1'b1)
				low_cycles++;
		end
		if (low_cycles != 0) begin
			$display("tx left idle for %0d cycles after a dropped write", low_cycles);
			errors++;
		end
	endtask

	task automatic receive_frame(input byte_t value);
		byte_t got;
		send_serial(value);
		wait_status(stat_rdrf, 1'b1, frame_cycles);
		expect_status(1'b1, 1'b1);
		read_reg(reg_data, got);
		check_byte("rx data", value, got);
		expect_status(1'b0, 1'b1);
		read_reg(reg_data, got);
		check_byte("empty data read", empty_read, got);
	endtask

	task automatic random_traffic(input int count);
		byte_t value;
		repeat (count) begin
			value = byte_t'($random(seed));
			receive_frame(value);
			transmit_frame(value);
		end
	endtask

	// ----------------------------------------
	// main sequence and watchdog
	// ----------------------------------------
	initial begin
		reset   = 1'b1;
		addr    = reg_status;
		data_in = '0;
		rd      = 1'b0;
		we      = 1'b0;
		rx      = 1'b1; // line idles high
		errors  = 0;
		checks  = 0;
		seed    = 32'h9bf46198;
		repeat (10) @(posedge clk);
		#2;
		reset = 1'b0;
		startup_idle();
		transmit_frame(8'hc5); // top bit gets masked
		busy_write(8'h41, 8'h5a);
		receive_frame(8'ha7);
		random_traffic(16);
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin
		#(watchdog_ns);
		$display("run timed out after %0d ns", watchdog_ns);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// ==== dv/clk_gen.sv ====
`timescale 1ns/1ps

module clk_gen #(
	parameter int half_period = 20 // 40 ns period
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #(half_period) clk = ~clk;
	end

endmodule

// ==== run.sh ====
#!/bin/sh
# build the ACIA testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module acia_tb -f verilog.f || exit 1
out=$(./obj_dir/Vacia_tb)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "TESTBENCH PASSED" && exit 0 || exit 1

// ==== verilog.f ====
verilog/serial_pkg.sv
verilog/acia_pkg.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/acia_regs.sv
verilog/acia.sv
dv/clk_gen.sv
dv/acia_tb.sv

// ==== verilog/acia.sv ====
`timescale 1ns/1ps

module acia
	import serial_pkg::*;
	import acia_pkg::*;
#(
	parameter int clks_per_bit = default_clks_per_bit
) (
	input  logic     clk,
	input  logic     reset,
	input  reg_sel_t addr,
	input  byte_t    data_in,
	input  logic     rd,
	input  logic     we,
	input  logic     rx,
	output byte_t    data_out,
	output logic     tx
);

	logic  tx_load;
	byte_t tx_char;
	logic  tx_ready;
	logic  rx_full;
	byte_t rx_char;
	logic  rx_taken;

	// host side registers
	acia_regs u_regs (
		.clk      (clk),
		.reset    (reset),
		.addr     (addr),
		.data_in  (data_in),
		.rd       (rd),
		.we       (we),
		.tx_ready (tx_ready),
		.rx_full  (rx_full),
		.rx_char  (rx_char),
		.data_out (data_out),
		.tx_load  (tx_load),
		.tx_char  (tx_char),
		.rx_taken (rx_taken)
	);

	uart_rx #(.clks_per_bit(clks_per_bit)) u_rx (
		.clk      (clk),
		.reset    (reset),
		.rx       (rx),
		.rx_taken (rx_taken),
		.rx_full  (rx_full),
		.rx_char  (rx_char)
	);

	uart_tx #(.clks_per_bit(clks_per_bit)) u_tx (
		.clk      (clk),
		.reset    (reset),
		.tx_load  (tx_load),
		.tx_char  (tx_char),
		.tx       (tx),
		.tx_ready (tx_ready)
	);

endmodule

// ==== verilog/acia_pkg.sv ====
package acia_pkg;

	typedef logic [7:0] byte_t;
	typedef logic       reg_sel_t;

	// ----------------------------------------
	// register map
	// ----------------------------------------
	localparam reg_sel_t reg_status = 1'b0; // status on read
	localparam reg_sel_t reg_data   = 1'b1;

	// status bit positions, the rest read as 0
	localparam int stat_rdrf = 0;
	localparam int stat_tdre = 1;
	localparam int stat_irq  = 5; // copy of rdrf

	localparam byte_t empty_read = 8'hff; // data read with nothing received
	localparam byte_t char_mask  = 8'h7f; // 7-bit characters on write

endpackage

// ==== verilog/acia_regs.sv ====
`timescale 1ns/1ps

module acia_regs
	import acia_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  reg_sel_t addr,
	input  byte_t    data_in,
	input  logic     rd,
	input  logic     we,
	input  logic     tx_ready,
	input  logic     rx_full,
	input  byte_t    rx_char,
	output byte_t    data_out,
	output logic     tx_load,
	output byte_t    tx_char,
	output logic     rx_taken
);

	byte_t status;
	byte_t rd_data;

	// ----------------------------------------
	// strobes to the serial engines
	// ----------------------------------------
	assign tx_load  = we && (addr == reg_data);
	assign tx_char  = data_in & char_mask;
	assign rx_taken = rd && (addr == reg_data); // clears rx_full next cycle

	// status byte, irq follows rdrf
	always_comb begin
		status            = '0;
		status[stat_rdrf] = rx_full;
		status[stat_tdre] = tx_ready;
		status[stat_irq]  = rx_full;
	end

	always_comb begin
		if (addr == reg_status)
			rd_data = status;
		else if (rx_full)
			rd_data = rx_char;
		else
			rd_data = empty_read; // nothing received
	end

	// read result, valid the cycle after rd
	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			data_out <= '0;
		else if (rd)
			data_out <= rd_data;
	end

endmodule

// ==== verilog/serial_pkg.sv ====
package serial_pkg;

	// ----------------------------------------
	// frame format
	// ----------------------------------------
	localparam int data_bits   = 8;
	localparam int frame_bits  = 10; // start + 8 data + stop
	localparam int warmup_bits = 15; // idle bit periods after reset

	// ----------------------------------------
	// bit timing
	// ----------------------------------------
	localparam int default_clks_per_bit = 1250; // 12 MHz / 9600 baud

	typedef logic [3:0]  bit_cnt_t;
	typedef logic [15:0] div_cnt_t;

	// receiver and transmitter FSMs
	typedef enum logic [1:0] {rx_idle, rx_start, rx_data, rx_stop} rx_state_t;
	typedef enum logic [1:0] {tx_warmup, tx_idle, tx_send} tx_state_t;

endpackage

// ==== verilog/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx
	import serial_pkg::*;
	import acia_pkg::*;
#(
	parameter int clks_per_bit = default_clks_per_bit
) (
	input  logic  clk,
	input  logic  reset,
	input  logic  rx,
	input  logic  rx_taken,
	output logic  rx_full,
	output byte_t rx_char
);

	localparam div_cnt_t half_last = div_cnt_t'(clks_per_bit / 2 - 1);
	localparam div_cnt_t bit_last  = div_cnt_t'(clks_per_bit - 1);
	localparam bit_cnt_t data_last = bit_cnt_t'(data_bits - 1);

	rx_state_t state;
	div_cnt_t  div_cnt;
	bit_cnt_t  bit_cnt;
	logic      rx_meta;
	logic      rx_sync;
	byte_t     pattern;
	logic      bit_done;

	assign bit_done = (div_cnt == bit_last);

	// two-flop synchronizer, line idles high
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
		end
	end

	// ----------------------------------------
	// receive FSM
	// ----------------------------------------
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state   <= rx_idle;
			div_cnt <= '0;
			bit_cnt <= '0;
			rx_full <= 1'b0;
		end else begin
			if (rx_taken)
				rx_full <= 1'b0;
			case (state)
				rx_idle: begin
					div_cnt <= '0;
					if (!rx_sync)
						state <= rx_start;
				end
				rx_start: begin
					div_cnt <= div_cnt + 1'b1;
					if (div_cnt == half_last) begin
						div_cnt <= '0;
						bit_cnt <= '0;
						state   <= rx_sync ? rx_idle : rx_data; // glitch, not a start bit
					end
				end
				rx_data: begin
					div_cnt <= div_cnt + 1'b1;
					if (bit_done) begin
						div_cnt <= '0;
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == data_last)
							state <= rx_stop;
					end
				end
				default: begin // rx_stop
					div_cnt <= div_cnt + 1'b1;
					if (bit_done) begin
						rx_full <= 1'b1; // new frame wins over a read
						state   <= rx_idle;
					end
				end
			endcase
		end
	end

	// data path, LSB arrives first
	always_ff @(posedge clk) begin
		if (state == rx_data && bit_done)
			pattern <= {rx_sync, pattern[7:1]};
		if (state == rx_stop && bit_done)
			rx_char <= pattern; // overwrites an unread byte
	end

endmodule

// ==== verilog/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx
	import serial_pkg::*;
	import acia_pkg::*;
#(
	parameter int clks_per_bit = default_clks_per_bit
) (
	input  logic  clk,
	input  logic  reset,
	input  logic  tx_load,
	input  byte_t tx_char,
	output logic  tx,
	output logic  tx_ready
);

	localparam div_cnt_t bit_last   = div_cnt_t'(clks_per_bit - 1);
	localparam bit_cnt_t warm_last  = bit_cnt_t'(warmup_bits - 1);
	localparam bit_cnt_t frame_last = bit_cnt_t'(frame_bits - 1);

	tx_state_t              state;
	div_cnt_t               div_cnt;
	bit_cnt_t               bit_cnt;
	logic [frame_bits-1:0]  shift_reg;
	logic                   bit_done;

	assign bit_done = (div_cnt == bit_last);
	assign tx       = shift_reg[0];
	assign tx_ready = (state == tx_idle);

	// ----------------------------------------
	// transmit FSM
	// ----------------------------------------
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state     <= tx_warmup;
			div_cnt   <= '0;
			bit_cnt   <= '0;
			shift_reg <= '1; // line high through warm-up
		end else begin
			case (state)
				tx_warmup: begin
					div_cnt <= div_cnt + 1'b1;
					if (bit_done) begin
						div_cnt <= '0;
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == warm_last)
							state <= tx_idle;
					end
				end
				tx_idle: begin
					div_cnt <= '0;
					bit_cnt <= '0;
					if (tx_load) begin
						shift_reg <= {1'b1, tx_char, 1'b0}; // stop, data, start
						state     <= tx_send;
					end
				end
				default: begin // tx_send, loads here are dropped
					div_cnt <= div_cnt + 1'b1;
					if (bit_done) begin
						div_cnt   <= '0;
						bit_cnt   <= bit_cnt + 1'b1;
						shift_reg <= {1'b1, shift_reg[frame_bits-1:1]};
						if (bit_cnt == frame_last)
							state <= tx_idle; // end of stop bit
					end
				end
			endcase
		end
	end

endmodule
